// ==== compile.f ====
+incdir+source
source/soc_pkg.sv
source/soc_if.sv
source/uart_tx.sv
source/line_mem.sv
source/dcache.sv
source/io_regs.sv
source/soc_top.sv
dv/soc_assert.sv
dv/soc_tb.sv

// ==== dv/soc_assert.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_assert (
  input logic clk,
  input logic rst_n,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic req,
  input logic done,
  input logic busy
);

  localparam int FRAME_CYCLES = 10 * `SOC_UART_CLKS_PER_BIT;

  int busy_len;

  // Length of the current busy stretch in cycles
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_len <= 0;
    end else if (busy) begin
      busy_len <= busy_len + 1;
    end else begin
      busy_len <= 0;
    end
  end

  ack_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> (cyc && stb))
    else $error("ack raised without cyc and stb");

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    ack |=> !ack)
    else $error("ack held for more than one cycle");

  req_until_done: assert property (@(posedge clk) disable iff (!rst_n)
    (req && !done) |=> req)
    else $error("req dropped before done");

  busy_whole_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> (busy_len == FRAME_CYCLES))
    else $error("busy dropped before the frame ended");

endmodule

bind dcache soc_assert u_dcache_chk (
  .clk  (clk),
  .rst_n(rst_n),
  .cyc  (bus.cyc),
  .stb  (bus.stb),
  .ack  (bus.ack),
  .req  (mem.req),
  .done (mem.done),
  .busy (1'b0)
);

bind io_regs soc_assert u_io_chk (
  .clk  (clk),
  .rst_n(rst_n),
  .cyc  (bus.cyc),
  .stb  (bus.stb),
  .ack  (bus.ack),
  .req  (1'b0),
  .done (1'b0),
  .busy (tx_busy)
);

// ==== dv/soc_tb.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_tb;
  import soc_pkg::*;

  localparam int CLK_HALF = 2;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY = 1;
  localparam int MEM_WORDS = `SOC_MEM_LINES * `SOC_LINE_WORDS;
  localparam int BIT_CLKS = `SOC_UART_CLKS_PER_BIT;
  localparam int FRAME_CYCLES = 10 * BIT_CLKS;
  localparam int ACCESS_CYCLES = `SOC_MEM_LATENCY + 20;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_IO_WRITE,
    OP_IO_READ
  } op_e;

  typedef struct {
    op_e         op;
    soc_addr_u   adr;
    logic [3:0]  sel;
    logic [31:0] data;
    logic [31:0] exp_val;
  } entry_t;

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  soc_addr_u              wb_adr;
  logic [3:0]             wb_sel;
  logic [`SOC_DATA_W-1:0] wb_dat_w;
  logic [`SOC_DATA_W-1:0] wb_dat_r;
  logic                   wb_ack;
  logic [3:0]             led;
  logic                   uart_tx;

  // Reference model of memory words and cache tags
  logic [31:0]      mem_model [MEM_WORDS];
  logic             valid_model [`SOC_CACHE_LINES];
  logic [TAG_W-1:0] tag_model [`SOC_CACHE_LINES];
  logic [31:0]      miss_model;
  logic [3:0]       led_model;
  entry_t           stim [$];
  integer           seed;
  int               wd_cycles;

  soc_top u_soc_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_sel  (wb_sel),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .led     (led),
    .uart_tx (uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic stop_with_error(string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(string name, logic [`SOC_DATA_W-1:0] got,
                            logic [`SOC_DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_led(logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Error: led got %h expected %h", got, exp));
    end
  endtask

  task automatic check_miss_cnt(logic [`SOC_DATA_W-1:0] got, logic [`SOC_DATA_W-1:0] exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Error: miss_cnt got %h expected %h", got, exp));
    end
  endtask

  function automatic soc_addr_u io_addr(io_reg_e r);
    soc_addr_u a;
    a = '0;
    a.io.region = 1'b1;
    a.io.sel = r;
    return a;
  endfunction

  // Holds the request until ack, then drops it after the ack edge
  task automatic wb_access(logic we, soc_addr_u adr, logic [3:0] sel, logic [31:0] wdata,
                           output logic [31:0] rdata);
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_sel = sel;
    wb_dat_w = wdata;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic add_entry(op_e op, soc_addr_u adr, logic [3:0] sel, logic [31:0] data,
                           logic [31:0] exp_val);
    entry_t e;
    e.op = op;
    e.adr = adr;
    e.sel = sel;
    e.data = data;
    e.exp_val = exp_val;
    stim.push_back(e);
  endtask

  task automatic build_stim();
    // Full and partial writes merged into one word, then cold and warm reads
    add_entry(OP_IO_READ, io_addr(REG_UART_STAT), 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_UART_DATA), 4'hf, '0, '0);
    add_entry(OP_WRITE, 32'h0000_0010, 4'hf, $random(seed), '0);
    add_entry(OP_WRITE, 32'h0000_0010, 4'h5, $random(seed), '0);
    add_entry(OP_READ, 32'h0000_0010, 4'hf, '0, '0);
    add_entry(OP_WRITE, 32'h0000_0014, 4'h8, $random(seed), '0);
    add_entry(OP_READ, 32'h0000_0014, 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
    add_entry(OP_READ, 32'h0000_0018, 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
    // Same index, other tag
    add_entry(OP_READ, 32'h0000_0110, 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
    add_entry(OP_READ, 32'h0000_0010, 4'hf, '0, '0);
    // Write-through proven by evicting the written line and reading it back
    add_entry(OP_READ, 32'h0000_0224, 4'hf, '0, '0);
    add_entry(OP_WRITE, 32'h0000_0224, 4'hf, $random(seed), '0);
    add_entry(OP_READ, 32'h0000_0324, 4'hf, '0, '0);
    add_entry(OP_READ, 32'h0000_0224, 4'hf, '0, '0);
    add_entry(OP_WRITE, 32'h0000_0328, 4'h3, $random(seed), '0);
    add_entry(OP_READ, 32'h0000_0328, 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
    add_entry(OP_IO_WRITE, io_addr(REG_LED), 4'hf, $random(seed), '0);
    add_entry(OP_IO_READ, io_addr(REG_LED), 4'hf, '0, '0);
    add_entry(OP_IO_WRITE, io_addr(REG_LED), 4'hf, $random(seed), '0);
    add_entry(OP_IO_READ, io_addr(REG_LED), 4'hf, '0, '0);
    add_entry(OP_IO_WRITE, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
    add_entry(OP_READ, 32'h0000_0110, 4'hf, '0, '0);
    add_entry(OP_IO_READ, io_addr(REG_MISS_CNT), 4'hf, '0, '0);
  endtask

  task automatic apply_entry(entry_t e);
    logic [31:0]      rdata;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tg;
    int               wi;
    idx = e.adr.cache.index;
    tg = e.adr.cache.tag;
    wi = int'({e.adr.cache.tag, e.adr.cache.index, e.adr.cache.word});
    case (e.op)
      OP_WRITE: begin
        wb_access(1'b1, e.adr, e.sel, e.data, rdata);
        for (int b = 0; b < 4; b++) begin
          if (e.sel[b]) begin
            mem_model[wi][8*b +: 8] = e.data[8*b +: 8];
          end
        end
      end
      OP_READ: begin
        if (!(valid_model[idx] && (tag_model[idx] == tg))) begin
          miss_model = miss_model + 1;
          valid_model[idx] = 1'b1;
          tag_model[idx] = tg;
        end
        wb_access(1'b0, e.adr, e.sel, '0, rdata);
        check_word("wb_dat_r", rdata, mem_model[wi]);
      end
      OP_IO_WRITE: begin
        wb_access(1'b1, e.adr, e.sel, e.data, rdata);
        if (e.adr.io.sel == REG_LED) begin
          led_model = e.data[3:0];
          check_led(led, led_model);
        end else if (e.adr.io.sel == REG_MISS_CNT) begin
          miss_model = '0;
        end
      end
      default: begin
        wb_access(1'b0, e.adr, e.sel, '0, rdata);
        if (e.adr.io.sel == REG_LED) begin
          check_word("wb_dat_r", rdata, {28'h0, led_model});
        end else if (e.adr.io.sel == REG_MISS_CNT) begin
          check_miss_cnt(rdata, miss_model);
        end else begin
          check_word("wb_dat_r", rdata, e.exp_val);
        end
      end
    endcase
  endtask

  // Samples each bit at its middle
  task automatic receive_byte(output logic [7:0] b);
    @(negedge uart_tx);
    repeat (BIT_CLKS / 2) @(posedge clk);
    #DRIVE_DELAY;
    if (uart_tx !== 1'b0) begin
      stop_with_error("UART start bit was not low at mid-bit");
    end
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(posedge clk);
      #DRIVE_DELAY;
      b[i] = uart_tx;
    end
    repeat (BIT_CLKS) @(posedge clk);
    #DRIVE_DELAY;
    if (uart_tx !== 1'b1) begin
      stop_with_error("UART stop bit was not high at mid-bit");
    end
  endtask

  task automatic uart_frame();
    logic [7:0]  tx_byte;
    logic [7:0]  rx_byte;
    logic [31:0] rdata;
    tx_byte = 8'($random(seed));
    fork
      receive_byte(rx_byte);
      begin
        wb_access(1'b1, io_addr(REG_UART_DATA), 4'h1, {24'h0, tx_byte}, rdata);
        wb_access(1'b0, io_addr(REG_UART_STAT), 4'hf, '0, rdata);
        check_word("uart_stat", rdata, 32'h1);
        // Dropped, the line is still busy
        wb_access(1'b1, io_addr(REG_UART_DATA), 4'h1, {24'h0, ~tx_byte}, rdata);
      end
    join
    check_word("uart_rx_byte", {24'h0, rx_byte}, {24'h0, tx_byte});
    repeat (BIT_CLKS / 2 + 1) @(posedge clk);
    wb_access(1'b0, io_addr(REG_UART_STAT), 4'hf, '0, rdata);
    check_word("uart_stat", rdata, 32'h0);
  endtask

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    stop_with_error("Timeout: the run did not finish in the expected time");
  end

  initial begin
    seed = 32'ha64b;
    wd_cycles = 0;
    rst_n = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_sel = '0;
    wb_dat_w = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    for (int i = 0; i < `SOC_CACHE_LINES; i++) begin
      valid_model[i] = 1'b0;
      tag_model[i] = '0;
    end
    miss_model = '0;
    led_model = '0;
    build_stim();
    wd_cycles = RESET_CYCLES + stim.size() * ACCESS_CYCLES + 2 * FRAME_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    check_led(led, 4'h0);
    if (uart_tx !== 1'b1) begin
      stop_with_error("uart_tx is not idle after reset");
    end
    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    uart_frame();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_tb -f compile.f -o soc_sim

# The simulator status is masked by tee, the log search decides
./obj_dir/soc_sim | tee sim.log

if grep -qx "Test passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== source/dcache.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module dcache (
  input  logic       clk,
  input  logic       rst_n,
  soc_bus_if.slave   bus,
  line_mem_if.master mem,
  output logic       miss_pulse
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_WRITE,
    ST_RESPOND
  } state_e;

  state_e                     state;
  cache_addr_t                addr_c;
  logic                       start;
  logic                       hit;
  logic [`SOC_CACHE_LINES-1:0] valid;
  logic [TAG_W-1:0]           tag_arr [`SOC_CACHE_LINES];
  soc_line_t                  data_arr [`SOC_CACHE_LINES];
  logic [`SOC_DATA_W-1:0]     dat_r_q;

  assign addr_c = bus.adr.cache;
  assign start  = (state == ST_IDLE) && bus.cyc && bus.stb;
  assign hit    = valid[addr_c.index] && (tag_arr[addr_c.index] == addr_c.tag);

  // Write ack comes straight from done, read ack from the respond state
  assign bus.ack   = (state == ST_RESPOND) || ((state == ST_WRITE) && mem.done);
  assign bus.dat_r = dat_r_q;

  assign mem.req   = (state == ST_FILL) || (state == ST_WRITE);
  assign mem.we    = (state == ST_WRITE);
  assign mem.addr  = {addr_c.tag, addr_c.index};
  assign mem.word  = addr_c.word;
  assign mem.wsel  = bus.sel;
  assign mem.wdata = bus.dat_w;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      valid      <= '0;
      miss_pulse <= 1'b0;
    end else begin
      miss_pulse <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            if (bus.we) begin
              state <= ST_WRITE;
            end else if (hit) begin
              state <= ST_RESPOND;
            end else begin
              state <= ST_FILL;
            end
          end
        end
        ST_FILL: begin
          if (mem.done) begin
            valid[addr_c.index] <= 1'b1;
            miss_pulse          <= 1'b1;
            state               <= ST_RESPOND;
          end
        end
        ST_WRITE: begin
          if (mem.done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start && !bus.we && hit) begin
      dat_r_q <= data_arr[addr_c.index][addr_c.word];
    end
    // Install the filled line and answer from it in the same edge
    if ((state == ST_FILL) && mem.done) begin
      tag_arr[addr_c.index]  <= addr_c.tag;
      data_arr[addr_c.index] <= mem.rdata;
      dat_r_q                <= mem.rdata[addr_c.word];
    end
    // No write-allocate, only a resident line is updated
    if ((state == ST_WRITE) && mem.done && hit) begin
      for (int b = 0; b < 4; b++) begin
        if (bus.sel[b]) begin
          data_arr[addr_c.index][addr_c.word][8*b +: 8] <= bus.dat_w[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== source/io_regs.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module io_regs (
  input  logic       clk,
  input  logic       rst_n,
  soc_bus_if.slave   bus,
  input  logic       miss_pulse,
  output logic [3:0] led,
  output logic       uart_tx
);
  import soc_pkg::*;

  io_reg_e                reg_sel;
  logic                   access;
  logic                   ack_q;
  logic                   tx_start;
  logic                   tx_busy;
  logic [`SOC_DATA_W-1:0] miss_cnt;
  logic [`SOC_DATA_W-1:0] dat_r_q;

  assign reg_sel = bus.adr.io.sel;
  // Request is still up in the ack cycle, ignore it there
  assign access  = bus.cyc && bus.stb && !ack_q;

  // Sends while busy are dropped, the write is still acked
  assign tx_start = access && bus.we && (reg_sel == REG_UART_DATA) && !tx_busy;

  assign bus.ack   = ack_q;
  assign bus.dat_r = dat_r_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      led      <= '0;
      miss_cnt <= '0;
    end else begin
      ack_q <= access;
      if (access && bus.we && (reg_sel == REG_MISS_CNT)) begin
        miss_cnt <= '0;
      end else if (miss_pulse) begin
        miss_cnt <= miss_cnt + 1'b1;
      end
      if (access && bus.we && (reg_sel == REG_LED) && bus.sel[0]) begin
        led <= bus.dat_w[3:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (reg_sel)
        REG_LED:       dat_r_q <= {{(`SOC_DATA_W - 4){1'b0}}, led};
        REG_UART_STAT: dat_r_q <= {{(`SOC_DATA_W - 1){1'b0}}, tx_busy};
        REG_MISS_CNT:  dat_r_q <= miss_cnt;
        default:       dat_r_q <= '0;
      endcase
    end
  end

  uart_tx uart (
    .clk  (clk),
    .rst_n(rst_n),
    .start(tx_start),
    .data (bus.dat_w[7:0]),
    .busy (tx_busy),
    .txd  (uart_tx)
  );

endmodule

// ==== source/line_mem.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module line_mem (
  input logic       clk,
  input logic       rst_n,
  line_mem_if.slave mem
);
  import soc_pkg::*;

  localparam int CNT_W = $clog2(`SOC_MEM_LATENCY + 1);

  soc_line_t        store [`SOC_MEM_LINES];
  soc_line_t        rdata_q;
  logic [CNT_W-1:0] cnt;
  logic             fire;
  logic             done_q;

  initial begin
    for (int i = 0; i < `SOC_MEM_LINES; i++) begin
      store[i] = '0;
    end
  end

  // Last counting edge, the access happens here and done follows
  assign fire = (cnt == CNT_W'(`SOC_MEM_LATENCY - 1));

  assign mem.done  = done_q;
  assign mem.rdata = rdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt    <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (fire) begin
        cnt    <= '0;
        done_q <= 1'b1;
      end else if (cnt != '0) begin
        cnt <= cnt + 1'b1;
      end else if (mem.req && !done_q) begin
        // req is still high in the done cycle, so do not restart then
        cnt <= CNT_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      rdata_q <= store[mem.addr];
      if (mem.we) begin
        for (int b = 0; b < 4; b++) begin
          if (mem.wsel[b]) begin
            store[mem.addr][mem.word][8*b +: 8] <= mem.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== source/soc_if.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

// Wishbone classic slave bus between the decoder and one target
interface soc_bus_if;
  import soc_pkg::*;

  logic                   cyc;
  logic                   stb;
  logic                   we;
  soc_addr_u              adr;
  logic [3:0]             sel;
  logic [`SOC_DATA_W-1:0] dat_w;
  logic [`SOC_DATA_W-1:0] dat_r;
  logic                   ack;

  modport master(output cyc, stb, we, adr, sel, dat_w, input dat_r, ack);
  modport slave(input cyc, stb, we, adr, sel, dat_w, output dat_r, ack);

endinterface

// Line request/done channel from the cache to its backing store
interface line_mem_if;
  import soc_pkg::*;

  logic                   req;
  logic                   we;
  logic [LINE_ADDR_W-1:0] addr;
  logic [WORD_W-1:0]      word;
  logic [3:0]             wsel;
  logic [`SOC_DATA_W-1:0] wdata;
  soc_line_t              rdata;
  logic                   done;

  modport master(output req, we, addr, word, wsel, wdata, input rdata, done);
  modport slave(input req, we, addr, word, wsel, wdata, output rdata, done);

endinterface

// ==== source/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Cache geometry, one line is 128 bits
`define SOC_LINE_WORDS 4
`define SOC_CACHE_LINES 16

// Backing store, 4 KB of lines
`define SOC_MEM_LINES 256
`define SOC_MEM_LATENCY 4

// UART bit period in clocks
`define SOC_UART_CLKS_PER_BIT 8

`endif

// ==== source/soc_pkg.sv ====
`include "soc_params.svh"

package soc_pkg;

  localparam int IDX_W = $clog2(`SOC_CACHE_LINES);
  localparam int WORD_W = $clog2(`SOC_LINE_WORDS);
  localparam int LINE_ADDR_W = $clog2(`SOC_MEM_LINES);
  localparam int TAG_W = LINE_ADDR_W - IDX_W;
  localparam int CACHE_PAD_W = `SOC_ADDR_W - 1 - TAG_W - IDX_W - WORD_W - 2;
  localparam int IO_PAD_W = `SOC_ADDR_W - 1 - 2 - 2;

  typedef enum logic [1:0] {
    REG_LED,
    REG_UART_DATA,
    REG_UART_STAT,
    REG_MISS_CNT
  } io_reg_e;

  // Upper address bits above the tag alias onto the same lines
  typedef struct packed {
    logic                   region;
    logic [CACHE_PAD_W-1:0] unused;
    logic [TAG_W-1:0]       tag;
    logic [IDX_W-1:0]       index;
    logic [WORD_W-1:0]      word;
    logic [1:0]             byte_off;
  } cache_addr_t;

  typedef struct packed {
    logic                region;
    logic [IO_PAD_W-1:0] unused;
    io_reg_e             sel;
    logic [1:0]          byte_off;
  } io_addr_t;

  typedef union packed {
    cache_addr_t cache;
    io_addr_t    io;
  } soc_addr_u;

  typedef logic [`SOC_LINE_WORDS-1:0][`SOC_DATA_W-1:0] soc_line_t;

endpackage

// ==== source/soc_top.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module soc_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  soc_pkg::soc_addr_u     wb_adr,
  input  logic [3:0]             wb_sel,
  input  logic [`SOC_DATA_W-1:0] wb_dat_w,
  output logic [`SOC_DATA_W-1:0] wb_dat_r,
  output logic                   wb_ack,
  output logic [3:0]             led,
  output logic                   uart_tx
);
  import soc_pkg::*;

  logic sel_io;
  logic miss_pulse;

  soc_bus_if  mem_bus ();
  soc_bus_if  io_bus ();
  line_mem_if mem_if ();

  // Bit 31 splits memory from I/O
  assign sel_io = wb_adr.cache.region;

  assign mem_bus.cyc   = wb_cyc;
  assign mem_bus.stb   = wb_stb && !sel_io;
  assign mem_bus.we    = wb_we;
  assign mem_bus.adr   = wb_adr;
  assign mem_bus.sel   = wb_sel;
  assign mem_bus.dat_w = wb_dat_w;

  assign io_bus.cyc   = wb_cyc;
  assign io_bus.stb   = wb_stb && sel_io;
  assign io_bus.we    = wb_we;
  assign io_bus.adr   = wb_adr;
  assign io_bus.sel   = wb_sel;
  assign io_bus.dat_w = wb_dat_w;

  // Address is held until ack, so the response mux follows it
  assign wb_dat_r = sel_io ? io_bus.dat_r : mem_bus.dat_r;
  assign wb_ack   = sel_io ? io_bus.ack : mem_bus.ack;

  dcache cache (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (mem_bus),
    .mem       (mem_if),
    .miss_pulse(miss_pulse)
  );

  line_mem dmem (
    .clk  (clk),
    .rst_n(rst_n),
    .mem  (mem_if)
  );

  io_regs io (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (io_bus),
    .miss_pulse(miss_pulse),
    .led       (led),
    .uart_tx   (uart_tx)
  );

endmodule

// ==== source/uart_tx.sv ====
`timescale 1ns/10ps
`include "soc_params.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       busy,
  output logic       txd
);

  localparam int CLK_W = $clog2(`SOC_UART_CLKS_PER_BIT);

  logic [CLK_W-1:0] clk_cnt;
  logic [3:0]       bit_cnt;
  logic             bit_end;
  logic [8:0]       shift;

  assign bit_end = (clk_cnt == CLK_W'(`SOC_UART_CLKS_PER_BIT - 1));

  // Bit 0 of the frame is the start bit, bit 9 the stop bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      txd     <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        txd     <= 1'b0;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end
    end else if (bit_end) begin
      clk_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else begin
        txd     <= shift[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Data LSB first, stop bit shifted in behind it
  always_ff @(posedge clk) begin
    if (!busy && start) begin
      shift <= {1'b1, data};
    end else if (busy && bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule
